/* conv_pe_pkg.sv */
`default_nettype none

package conv_pe_pkg;

    // Data widths
    localparam int PIXEL_WIDTH  = 16;
    localparam int KERNEL_WIDTH = 16;
    localparam int RESULT_WIDTH = 48;

    // Taps in a 3x3 window
    localparam int WINDOW_SIZE = 9;

    // Scalar data types
    typedef logic signed [PIXEL_WIDTH-1:0]  pixel_t;
    typedef logic signed [KERNEL_WIDTH-1:0] weight_t;
    typedef logic signed [RESULT_WIDTH-1:0] result_t;

    // Packed window, tap 0 in the lowest bits (x00, x01, x02, x10 ... x22)
    typedef logic [WINDOW_SIZE*PIXEL_WIDTH-1:0] window_t;

    // Packed kernel, same tap order as the window
    typedef logic [WINDOW_SIZE*KERNEL_WIDTH-1:0] kernel_t;

    // Control unit states
    typedef enum logic [1:0] {
        idle,
        wait_kernel,
        stream,
        drain
    } pe_state_t;

endpackage

`default_nettype wire

/* pe_kernel_mac.sv */
`default_nettype none

module pe_kernel_mac #(
    parameter int ROW_LENGTH = 16,
    localparam int COL_WIDTH = (ROW_LENGTH > 1) ? $clog2(ROW_LENGTH) : 1
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  wr_kernel,
    input  wire logic                  clr_kernel,
    input  wire conv_pe_pkg::kernel_t  kernel,
    input  wire logic                  issue,
    input  wire conv_pe_pkg::window_t  window,
    input  wire logic                  first_channel,
    input  wire logic                  last_channel,
    input  wire logic [COL_WIDTH-1:0]  column,
    output logic                       mac_valid,
    output conv_pe_pkg::result_t       mac_sum,
    output logic                       mac_first,
    output logic                       mac_last,
    output logic [COL_WIDTH-1:0]       mac_column
);

    localparam int TAPS          = conv_pe_pkg::WINDOW_SIZE;
    localparam int PW            = conv_pe_pkg::PIXEL_WIDTH;
    localparam int KW            = conv_pe_pkg::KERNEL_WIDTH;
    localparam int PRODUCT_WIDTH = PW + KW;

    conv_pe_pkg::kernel_t          kernel_q;
    conv_pe_pkg::pixel_t           pix [TAPS];
    conv_pe_pkg::weight_t          wgt [TAPS];
    logic signed [PRODUCT_WIDTH-1:0] prod_d [TAPS];
    logic signed [PRODUCT_WIDTH-1:0] prod_q [TAPS];
    conv_pe_pkg::result_t          sum_d;

    logic                 s1_valid;
    logic                 s1_first;
    logic                 s1_last;
    logic [COL_WIDTH-1:0] s1_column;

    // Kernel register, cleared at the end of every channel
    always_ff @(posedge clk) begin
        if (reset || clr_kernel) begin
            kernel_q <= '0;
        end else if (wr_kernel) begin
            kernel_q <= kernel;
        end
    end

    // Unpack taps and form the nine products
    always_comb begin
        for (int i = 0; i < TAPS; i++) begin
            pix[i]    = conv_pe_pkg::pixel_t'(window[i*PW +: PW]);
            wgt[i]    = conv_pe_pkg::weight_t'(kernel_q[i*KW +: KW]);
            prod_d[i] = pix[i] * wgt[i];
        end
    end

    // Stage 1
    always_ff @(posedge clk) begin
        for (int i = 0; i < TAPS; i++) begin
            prod_q[i] <= prod_d[i];
        end
        s1_first  <= first_channel;
        s1_last   <= last_channel;
        s1_column <= column;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue;
        end
    end

    // Adder tree, products sign-extended to the result width
    always_comb begin
        sum_d = '0;
        for (int i = 0; i < TAPS; i++) begin
            sum_d = sum_d + conv_pe_pkg::result_t'(prod_q[i]);
        end
    end

    // Stage 2
    always_ff @(posedge clk) begin
        mac_sum    <= sum_d;
        mac_first  <= s1_first;
        mac_last   <= s1_last;
        mac_column <= s1_column;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mac_valid <= 1'b0;
        end else begin
            mac_valid <= s1_valid;
        end
    end

endmodule

`default_nettype wire

/* psum_ram.sv */
`default_nettype none

module psum_ram #(
    parameter int ROW_LENGTH = 16,
    localparam int COL_WIDTH = (ROW_LENGTH > 1) ? $clog2(ROW_LENGTH) : 1
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  rd_en,
    input  wire logic [COL_WIDTH-1:0]  rd_column,
    input  wire logic                  mac_valid,
    input  wire conv_pe_pkg::result_t  mac_sum,
    input  wire logic                  mac_first,
    input  wire logic                  mac_last,
    input  wire logic [COL_WIDTH-1:0]  mac_column,
    input  wire conv_pe_pkg::result_t  bias,
    output logic                       push,
    output conv_pe_pkg::result_t       push_data
);

    // One partial sum per column
    conv_pe_pkg::result_t mem [ROW_LENGTH];

    conv_pe_pkg::result_t rd_word;
    conv_pe_pkg::result_t stored_word;
    conv_pe_pkg::result_t base_word;
    conv_pe_pkg::result_t acc_word;

    // Read issued on window acceptance
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_column];
        end
    end

    // Hold the read word until the stage-2 sum arrives
    always_ff @(posedge clk) begin
        stored_word <= rd_word;
    end

    // First channel starts from zero
    always_comb begin
        base_word = mac_first ? '0 : stored_word;
        acc_word  = base_word + mac_sum;
    end

    // Write back on every channel but the last
    always_ff @(posedge clk) begin
        if (mac_valid && !mac_last) begin
            mem[mac_column] <= acc_word;
        end
    end

    // Last channel adds the bias and hands the result to the FIFO
    always_ff @(posedge clk) begin
        if (mac_valid && mac_last) begin
            push_data <= acc_word + bias;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            push <= 1'b0;
        end else begin
            push <= mac_valid && mac_last;
        end
    end

endmodule

`default_nettype wire

/* result_fifo.sv */
`default_nettype none

module result_fifo #(
    parameter int FIFO_DEPTH = 8,
    parameter int ROW_LENGTH = 16,
    localparam int PTR_WIDTH   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1,
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1),
    localparam int COL_WIDTH   = (ROW_LENGTH > 1) ? $clog2(ROW_LENGTH) : 1
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  push,
    input  wire conv_pe_pkg::result_t  push_data,
    input  wire logic                  result_ready,
    output conv_pe_pkg::result_t       result,
    output logic                       result_valid,
    output logic                       result_last,
    output logic [COUNT_WIDTH-1:0]     count
);

    conv_pe_pkg::result_t mem [FIFO_DEPTH];

    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [COL_WIDTH-1:0] pop_column;
    logic                 full;
    logic                 wr_en;
    logic                 rd_en;

    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        next_ptr = (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_comb begin
        full         = (count == COUNT_WIDTH'(FIFO_DEPTH));
        result_valid = (count != '0);
        result       = mem[rd_ptr];
        wr_en        = push && !full;
        rd_en        = result_valid && result_ready;
        // Final column of the row, derived from the pop order
        result_last  = result_valid && (pop_column == COL_WIDTH'(ROW_LENGTH - 1));
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            pop_column <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr     <= next_ptr(rd_ptr);
                pop_column <= result_last ? '0 : pop_column + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* pe_control.sv */
`default_nettype none

module pe_control #(
    parameter int ROW_LENGTH   = 16,
    parameter int NUM_CHANNELS = 3,
    parameter int FIFO_DEPTH   = 8,
    localparam int COL_WIDTH   = (ROW_LENGTH > 1) ? $clog2(ROW_LENGTH) : 1,
    localparam int CH_WIDTH    = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1,
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1)
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    load_kernel,
    input  wire logic                    window_valid,
    input  wire logic [COUNT_WIDTH-1:0]  fifo_count,
    output logic                         window_ready,
    output logic                         wr_kernel,
    output logic                         clr_kernel,
    output logic                         issue,
    output logic                         first_channel,
    output logic                         last_channel,
    output logic                         column_enable,
    output logic                         column_clear,
    output logic                         kernel_needed,
    output logic                         pe_idle
);

    // Cycles from acceptance until the result is counted by the FIFO
    localparam int PUSH_LATENCY = 3;
    localparam int FLIGHT_WIDTH = $clog2(PUSH_LATENCY + 1);

    conv_pe_pkg::pe_state_t state;

    logic [CH_WIDTH-1:0]     channel;
    logic [COL_WIDTH-1:0]    window_count;
    logic [PUSH_LATENCY-1:0] flight_q;
    logic [FLIGHT_WIDTH-1:0] in_flight;
    logic                    fifo_room;
    logic                    row_done;

    // Last-channel results not yet in the FIFO count
    always_comb begin
        in_flight = '0;
        for (int i = 0; i < PUSH_LATENCY; i++) begin
            in_flight = in_flight + FLIGHT_WIDTH'(flight_q[i]);
        end
    end

    always_comb begin
        first_channel = (channel == '0);
        last_channel  = (channel == CH_WIDTH'(NUM_CHANNELS - 1));
        kernel_needed = (state == conv_pe_pkg::idle) || (state == conv_pe_pkg::wait_kernel);
        pe_idle       = (state == conv_pe_pkg::idle);
        wr_kernel     = load_kernel && kernel_needed;

        // Room for one more result once everything in flight has landed
        fifo_room     = (int'(fifo_count) + int'(in_flight)) < FIFO_DEPTH;
        window_ready  = (state == conv_pe_pkg::stream) && (!last_channel || fifo_room);
        issue         = window_valid && window_ready;

        row_done      = issue && (window_count == COL_WIDTH'(ROW_LENGTH - 1));
        clr_kernel    = row_done;
        column_enable = issue;
        column_clear  = row_done || pe_idle;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= conv_pe_pkg::idle;
            channel      <= '0;
            window_count <= '0;
            flight_q     <= '0;
        end else begin
            flight_q <= {flight_q[PUSH_LATENCY-2:0], issue && last_channel};

            if (issue) begin
                window_count <= row_done ? '0 : window_count + 1'b1;
            end

            case (state)
                conv_pe_pkg::idle,
                conv_pe_pkg::wait_kernel: begin
                    if (load_kernel) begin
                        state <= conv_pe_pkg::stream;
                    end
                end
                conv_pe_pkg::stream: begin
                    if (row_done) begin
                        if (last_channel) begin
                            state   <= conv_pe_pkg::drain;
                            channel <= '0;
                        end else begin
                            state   <= conv_pe_pkg::wait_kernel;
                            channel <= channel + 1'b1;
                        end
                    end
                end
                conv_pe_pkg::drain: begin
                    // Wait for the pipeline and the output stream to empty
                    if (in_flight == '0 && fifo_count == '0) begin
                        state <= conv_pe_pkg::idle;
                    end
                end
                default: begin
                    state <= conv_pe_pkg::idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* pe_with_buffers.sv */
`default_nettype none

module pe_with_buffers #(
    parameter int ROW_LENGTH   = 16,
    parameter int NUM_CHANNELS = 3,
    parameter int FIFO_DEPTH   = 8
) (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire conv_pe_pkg::kernel_t  kernel,
    input  wire logic                  load_kernel,
    input  wire conv_pe_pkg::result_t  bias,
    input  wire conv_pe_pkg::window_t  window,
    input  wire logic                  window_valid,
    output logic                       window_ready,
    output conv_pe_pkg::result_t       result,
    output logic                       result_valid,
    input  wire logic                  result_ready,
    output logic                       result_last,
    output logic                       kernel_needed,
    output logic                       pe_idle
);

    localparam int COL_WIDTH   = (ROW_LENGTH > 1) ? $clog2(ROW_LENGTH) : 1;
    localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

    // Control to datapath
    logic wr_kernel;
    logic clr_kernel;
    logic issue;
    logic first_channel;
    logic last_channel;
    logic column_enable;
    logic column_clear;

    // Column address counter
    logic [COL_WIDTH-1:0] column;

    // MAC to partial-sum RAM
    logic                 mac_valid;
    conv_pe_pkg::result_t mac_sum;
    logic                 mac_first;
    logic                 mac_last;
    logic [COL_WIDTH-1:0] mac_column;

    // RAM to FIFO
    logic                   push;
    conv_pe_pkg::result_t   push_data;
    logic [COUNT_WIDTH-1:0] fifo_count;

    always_ff @(posedge clk) begin
        if (reset || column_clear) begin
            column <= '0;
        end else if (column_enable) begin
            column <= column + 1'b1;
        end
    end

    pe_control #(
        .ROW_LENGTH(ROW_LENGTH),
        .NUM_CHANNELS(NUM_CHANNELS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_control (
        .clk(clk),
        .reset(reset),
        .load_kernel(load_kernel),
        .window_valid(window_valid),
        .fifo_count(fifo_count),
        .window_ready(window_ready),
        .wr_kernel(wr_kernel),
        .clr_kernel(clr_kernel),
        .issue(issue),
        .first_channel(first_channel),
        .last_channel(last_channel),
        .column_enable(column_enable),
        .column_clear(column_clear),
        .kernel_needed(kernel_needed),
        .pe_idle(pe_idle)
    );

    pe_kernel_mac #(
        .ROW_LENGTH(ROW_LENGTH)
    ) u_mac (
        .clk(clk),
        .reset(reset),
        .wr_kernel(wr_kernel),
        .clr_kernel(clr_kernel),
        .kernel(kernel),
        .issue(issue),
        .window(window),
        .first_channel(first_channel),
        .last_channel(last_channel),
        .column(column),
        .mac_valid(mac_valid),
        .mac_sum(mac_sum),
        .mac_first(mac_first),
        .mac_last(mac_last),
        .mac_column(mac_column)
    );

    // Read starts at acceptance with the live column address
    psum_ram #(
        .ROW_LENGTH(ROW_LENGTH)
    ) u_psum_ram (
        .clk(clk),
        .reset(reset),
        .rd_en(issue),
        .rd_column(column),
        .mac_valid(mac_valid),
        .mac_sum(mac_sum),
        .mac_first(mac_first),
        .mac_last(mac_last),
        .mac_column(mac_column),
        .bias(bias),
        .push(push),
        .push_data(push_data)
    );

    result_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .ROW_LENGTH(ROW_LENGTH)
    ) u_result_fifo (
        .clk(clk),
        .reset(reset),
        .push(push),
        .push_data(push_data),
        .result_ready(result_ready),
        .result(result),
        .result_valid(result_valid),
        .result_last(result_last),
        .count(fifo_count)
    );

endmodule

`default_nettype wire

/* tb_pe_with_buffers.sv */
`default_nettype none

module tb_pe_with_buffers;

    localparam int ROW_LENGTH   = 16;
    localparam int NUM_CHANNELS = 3;
    localparam int FIFO_DEPTH   = 8;
    localparam int TAPS         = conv_pe_pkg::WINDOW_SIZE;
    localparam int PW           = conv_pe_pkg::PIXEL_WIDTH;
    localparam int KW           = conv_pe_pkg::KERNEL_WIDTH;
    localparam int TIMEOUT      = 5000;
    localparam int STALL_CYCLES = 300;
    localparam logic [31:0] RANDOM_SEED = 32'h8eab24f1;

    logic                 clk;
    logic                 reset;
    conv_pe_pkg::kernel_t kernel;
    logic                 load_kernel;
    conv_pe_pkg::result_t bias;
    conv_pe_pkg::window_t window;
    logic                 window_valid;
    logic                 window_ready;
    conv_pe_pkg::result_t result;
    logic                 result_valid;
    logic                 result_ready;
    logic                 result_last;
    logic                 kernel_needed;
    logic                 pe_idle;

    // Stimulus and expected results of the current row
    conv_pe_pkg::pixel_t  pix_mem [NUM_CHANNELS][ROW_LENGTH][TAPS];
    conv_pe_pkg::weight_t wgt_mem [NUM_CHANNELS][TAPS];
    conv_pe_pkg::result_t bias_value;
    conv_pe_pkg::result_t expected [ROW_LENGTH];

    // Windows of the last channel taken by the DUT in the current row
    int last_channel_sent;

    int error_count;
    int check_count;

    pe_with_buffers #(
        .ROW_LENGTH(ROW_LENGTH),
        .NUM_CHANNELS(NUM_CHANNELS),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .kernel(kernel),
        .load_kernel(load_kernel),
        .bias(bias),
        .window(window),
        .window_valid(window_valid),
        .window_ready(window_ready),
        .result(result),
        .result_valid(result_valid),
        .result_ready(result_ready),
        .result_last(result_last),
        .kernel_needed(kernel_needed),
        .pe_idle(pe_idle)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compare_result(input conv_pe_pkg::result_t actual,
                                  input conv_pe_pkg::result_t expect_value,
                                  input string what);
        check_count++;
        if (actual !== expect_value) begin
            error_count++;
            $display("** Error at %0t: %s is %0d, expected %0d",
                     $time, what, actual, expect_value);
        end
    endtask

    task automatic compare_bit(input logic actual, input logic expect_value, input string what);
        check_count++;
        if (actual !== expect_value) begin
            error_count++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, actual, expect_value);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        error_count++;
        $display("Timeout at %0t: gave up waiting for %s", $time, what);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("Errors found");
        $finish;
    endtask

    function automatic conv_pe_pkg::window_t pack_window(input int ch, input int col);
        conv_pe_pkg::window_t w;
        w = '0;
        for (int i = 0; i < TAPS; i++) begin
            w[i*PW +: PW] = pix_mem[ch][col][i];
        end
        return w;
    endfunction

    function automatic conv_pe_pkg::kernel_t pack_kernel(input int ch);
        conv_pe_pkg::kernel_t k;
        k = '0;
        for (int i = 0; i < TAPS; i++) begin
            k[i*KW +: KW] = wgt_mem[ch][i];
        end
        return k;
    endfunction

    // Reference model, dot products summed over channels plus bias
    task automatic build_expected;
        conv_pe_pkg::result_t acc;
        for (int col = 0; col < ROW_LENGTH; col++) begin
            acc = bias_value;
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                for (int i = 0; i < TAPS; i++) begin
                    acc = acc + conv_pe_pkg::result_t'(pix_mem[ch][col][i])
                              * conv_pe_pkg::result_t'(wgt_mem[ch][i]);
                end
            end
            expected[col] = acc;
        end
    endtask

    task automatic fill_random_row;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            for (int i = 0; i < TAPS; i++) begin
                wgt_mem[ch][i] = conv_pe_pkg::weight_t'($urandom());
                for (int col = 0; col < ROW_LENGTH; col++) begin
                    pix_mem[ch][col][i] = conv_pe_pkg::pixel_t'($urandom());
                end
            end
        end
        bias_value = int'($urandom());
    endtask

    task automatic load_kernel_task(input int ch);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!kernel_needed && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!kernel_needed) begin
            stop_on_timeout("kernel_needed");
        end
        @(posedge clk);
        kernel      <= pack_kernel(ch);
        load_kernel <= 1'b1;
        @(posedge clk);
        load_kernel <= 1'b0;
        @(negedge clk);
        compare_bit(kernel_needed, 1'b0, "kernel_needed after kernel load");
        @(posedge clk);
    endtask

    task automatic send_row_task;
        int waited;
        last_channel_sent = 0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            load_kernel_task(ch);
            for (int col = 0; col < ROW_LENGTH; col++) begin
                window       <= pack_window(ch, col);
                window_valid <= 1'b1;
                waited = 0;
                @(negedge clk);
                while (!window_ready && waited < TIMEOUT) begin
                    @(negedge clk);
                    waited++;
                end
                if (!window_ready) begin
                    stop_on_timeout("window_ready");
                end
                // Transfer on this edge
                @(posedge clk);
                if (ch == NUM_CHANNELS - 1) begin
                    last_channel_sent++;
                end
            end
            window_valid <= 1'b0;
        end
    endtask

    task automatic collect_task(input int stall_cycles);
        int waited;
        @(posedge clk);
        result_ready <= (stall_cycles == 0);
        if (stall_cycles > 0) begin
            waited = 0;
            @(negedge clk);
            while (!result_valid && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!result_valid) begin
                stop_on_timeout("the first result before the stall");
            end
            // FIFO fills and the last channel must stop taking windows
            repeat (stall_cycles) @(negedge clk);
            compare_bit(window_ready, 1'b0, "window_ready with output stalled");
            compare_bit(logic'(last_channel_sent == FIFO_DEPTH), 1'b1,
                        "last channel windows taken equal to the FIFO depth");
            compare_bit(result_valid, 1'b1, "result_valid with output stalled");
            @(posedge clk);
            result_ready <= 1'b1;
        end
        for (int col = 0; col < ROW_LENGTH; col++) begin
            waited = 0;
            @(negedge clk);
            while (!result_valid && waited < TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!result_valid) begin
                stop_on_timeout("result_valid");
            end
            compare_result(result, expected[col], $sformatf("result of column %0d", col));
            compare_bit(result_last, logic'(col == ROW_LENGTH - 1),
                        $sformatf("result_last of column %0d", col));
            @(posedge clk);
        end
    endtask

    task automatic wait_idle;
        int waited;
        waited = 0;
        @(negedge clk);
        while (!pe_idle && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!pe_idle) begin
            stop_on_timeout("pe_idle");
        end
    endtask

    // One full row over all channels, then check that nothing is left over
    task automatic run_row(input int stall_cycles);
        @(posedge clk);
        bias <= bias_value;
        fork
            send_row_task();
            collect_task(stall_cycles);
        join
        wait_idle();
        compare_bit(kernel_needed, 1'b1, "kernel_needed after the row");
        compare_bit(result_valid, 1'b0, "result_valid after the row");
    endtask

    initial begin
        conv_pe_pkg::result_t weight_sum;

        void'($urandom(RANDOM_SEED));
        error_count  = 0;
        check_count  = 0;
        reset        = 1'b1;
        kernel       = '0;
        load_kernel  = 1'b0;
        bias         = '0;
        window       = '0;
        window_valid = 1'b0;
        result_ready = 1'b0;

        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Status right after reset
        @(negedge clk);
        compare_bit(kernel_needed, 1'b1, "kernel_needed after reset");
        compare_bit(pe_idle, 1'b1, "pe_idle after reset");
        compare_bit(window_ready, 1'b0, "window_ready after reset");
        compare_bit(result_valid, 1'b0, "result_valid after reset");
        compare_bit(result_last, 1'b0, "result_last after reset");

        // Known weights on the last channel, all-ones windows
        fill_random_row();
        weight_sum = '0;
        for (int i = 0; i < TAPS; i++) begin
            for (int ch = 0; ch < NUM_CHANNELS - 1; ch++) begin
                wgt_mem[ch][i] = '0;
            end
            wgt_mem[NUM_CHANNELS-1][i] = conv_pe_pkg::weight_t'(i * 3 - 7);
            weight_sum = weight_sum + conv_pe_pkg::result_t'(i * 3 - 7);
            for (int col = 0; col < ROW_LENGTH; col++) begin
                pix_mem[NUM_CHANNELS-1][col][i] = 16'sd1;
            end
        end
        for (int col = 0; col < ROW_LENGTH; col++) begin
            expected[col] = weight_sum + bias_value;
        end
        run_row(0);

        // Random rows, the second one with the output held off
        fill_random_row();
        build_expected();
        run_row(0);

        fill_random_row();
        build_expected();
        run_row(STALL_CYCLES);

        fill_random_row();
        build_expected();
        run_row(0);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* pe_with_buffers.f */
conv_pe_pkg.sv
pe_kernel_mac.sv
psum_ram.sv
result_fifo.sv
pe_control.sv
pe_with_buffers.sv
tb_pe_with_buffers.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_pe_with_buffers
FILELIST  = pe_with_buffers.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
